// ==== hw/ddr_ctrl_pkg.sv ====
`default_nettype none

package ddr_ctrl_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH = 8;            // 256 words
    localparam int ID_WIDTH   = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // one queued read or write command
    typedef struct packed {
        logic                  is_read;
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
    } cmd_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;              // id of an outstanding read
    } rd_tag_t;

endpackage

`default_nettype wire

// ==== hw/app_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface app_if;

    logic                                  cmd_en;
    logic                                  cmd_read;
    logic [ddr_ctrl_pkg::ADDR_WIDTH-1:0]   addr;
    ddr_ctrl_pkg::data_t                   wr_data;
    logic [ddr_ctrl_pkg::STRB_WIDTH-1:0]   wr_mask;    // 1 keeps the old byte
    logic                                  cmd_ready;
    ddr_ctrl_pkg::data_t                   rd_data;
    logic                                  rd_valid;   // no back-pressure

    modport issuer (
        output cmd_en, cmd_read, addr, wr_data, wr_mask,
        input  cmd_ready
    );

    modport mem (
        input  cmd_en, cmd_read, addr, wr_data, wr_mask,
        output cmd_ready, rd_data, rd_valid
    );

    modport rd_sink (
        input  rd_data, rd_valid
    );

endinterface

`default_nettype wire

// ==== hw/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  wire   ui_clk,
    input  wire   resetn,
    input  logic  push,
    input  item_t din,
    output logic  full,
    input  logic  pop,
    output item_t dout,
    output logic  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign dout    = mem[rd_ptr];

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cmd_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_fetch (
    input  wire                   ui_clk,
    input  wire                   resetn,
    input  ddr_ctrl_pkg::cmd_t    q_head,
    input  logic                  q_empty,
    output logic                  q_pop,
    app_if.issuer                 app,
    output logic                  tag_push,
    output ddr_ctrl_pkg::rd_tag_t tag,
    input  logic                  tag_ready
);

    typedef enum logic {
        FETCH_IDLE  = 1'b0,
        FETCH_ISSUE = 1'b1
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         can_issue;
    logic         accepted;

    // reads also need room for their tag
    assign can_issue = (state == FETCH_ISSUE) & ~q_empty & (~q_head.is_read | tag_ready);
    assign accepted  = can_issue & app.cmd_ready;

    assign app.cmd_en   = can_issue;
    assign app.cmd_read = q_head.is_read;
    assign app.addr     = q_head.addr;
    assign app.wr_data  = q_head.wdata;
    assign app.wr_mask  = ~q_head.wstrb;    // strobe to mask

    assign q_pop    = accepted;
    assign tag_push = accepted & q_head.is_read;
    assign tag.id   = q_head.id;

    always_comb begin
        state_next = state;
        case (state)
            FETCH_IDLE: begin
                if (!q_empty) begin
                    state_next = FETCH_ISSUE;
                end
            end
            FETCH_ISSUE: begin
                if (q_empty) begin
                    state_next = FETCH_IDLE;
                end
            end
            default: state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            state <= FETCH_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rd_resp_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module rd_resp_merge #(
    parameter int TAG_DEPTH = 8
) (
    input  wire                                 ui_clk,
    input  wire                                 resetn,
    input  logic                                tag_push,
    input  ddr_ctrl_pkg::rd_tag_t               tag,
    output logic                                tag_ready,
    app_if.rd_sink                              app,
    output logic                                rsp_valid,
    input  logic                                rsp_ready,
    output logic [ddr_ctrl_pkg::ID_WIDTH-1:0]   rsp_id,
    output ddr_ctrl_pkg::data_t                 rsp_data
);

    typedef enum logic {
        RESP_IDLE = 1'b0,
        RESP_BUSY = 1'b1
    } resp_state_t;

    resp_state_t           state;
    ddr_ctrl_pkg::rd_tag_t tag_head;
    ddr_ctrl_pkg::data_t   data_head;
    logic                  tag_full;
    logic                  tag_empty;
    logic                  data_empty;
    logic                  both_ready;
    logic                  take;

    sync_fifo #(
        .item_t (ddr_ctrl_pkg::rd_tag_t),
        .DEPTH  (TAG_DEPTH)
    ) u_tag_q (
        .ui_clk (ui_clk),
        .resetn (resetn),
        .push   (tag_push),
        .din    (tag),
        .full   (tag_full),
        .pop    (take),
        .dout   (tag_head),
        .empty  (tag_empty)
    );

    // never fills as each word has a tag still held
    sync_fifo #(
        .item_t (ddr_ctrl_pkg::data_t),
        .DEPTH  (TAG_DEPTH)
    ) u_data_q (
        .ui_clk (ui_clk),
        .resetn (resetn),
        .push   (app.rd_valid),
        .din    (app.rd_data),
        .full   (),
        .pop    (take),
        .dout   (data_head),
        .empty  (data_empty)
    );

    assign tag_ready  = ~tag_full;
    assign rsp_valid  = (state == RESP_BUSY);
    assign both_ready = ~tag_empty & ~data_empty;
    assign take       = both_ready & (~rsp_valid | rsp_ready);    // free or draining

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            state <= RESP_IDLE;
        end else if (take) begin
            state <= RESP_BUSY;
        end else if (rsp_ready) begin
            state <= RESP_IDLE;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (take) begin
            rsp_id   <= tag_head.id;
            rsp_data <= data_head;
        end
    end

endmodule

`default_nettype wire

// ==== hw/app_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module app_ram #(
    parameter int RD_LATENCY       = 3,
    parameter int REFRESH_INTERVAL = 64,
    parameter int REFRESH_CYCLES   = 4
) (
    input  wire ui_clk,
    input  wire resetn,
    app_if.mem  app
);

    localparam int WORDS = 2 ** ddr_ctrl_pkg::ADDR_WIDTH;
    localparam int REF_W = $clog2(REFRESH_INTERVAL);

    ddr_ctrl_pkg::data_t    mem [WORDS];
    ddr_ctrl_pkg::data_t    pipe_dat [RD_LATENCY];
    logic [RD_LATENCY-1:0]  pipe_vld;
    logic [REF_W-1:0]       ref_cnt;
    logic                   rd_accept;
    logic                   wr_accept;

    // refresh window sits at the end of each interval
    assign app.cmd_ready = (ref_cnt < REF_W'(REFRESH_INTERVAL - REFRESH_CYCLES));

    assign rd_accept = app.cmd_en & app.cmd_ready & app.cmd_read;
    assign wr_accept = app.cmd_en & app.cmd_ready & ~app.cmd_read;

    assign app.rd_valid = pipe_vld[RD_LATENCY-1];
    assign app.rd_data  = pipe_dat[RD_LATENCY-1];

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            ref_cnt <= '0;
        end else if (ref_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (wr_accept) begin
            for (int b = 0; b < ddr_ctrl_pkg::STRB_WIDTH; b++) begin
                if (!app.wr_mask[b]) begin
                    mem[app.addr][b*8 +: 8] <= app.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // one pipeline stage per cycle of read latency
    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld[0] <= rd_accept;
            for (int i = 1; i < RD_LATENCY; i++) begin
                pipe_vld[i] <= pipe_vld[i-1];
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        pipe_dat[0] <= mem[app.addr];
        for (int i = 1; i < RD_LATENCY; i++) begin
            pipe_dat[i] <= pipe_dat[i-1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/ddr_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ddr_ctrl_top #(
    parameter int CMD_DEPTH        = 4,
    parameter int TAG_DEPTH        = 8,
    parameter int RD_LATENCY       = 3,
    parameter int REFRESH_INTERVAL = 64,
    parameter int REFRESH_CYCLES   = 4
) (
    input  wire                                  ui_clk,
    input  wire                                  resetn,

    input  wire                                  cmd_valid,
    output logic                                 cmd_ready,
    input  wire                                  cmd_read,
    input  wire  [ddr_ctrl_pkg::ID_WIDTH-1:0]    cmd_id,
    input  wire  [ddr_ctrl_pkg::ADDR_WIDTH-1:0]  cmd_addr,
    input  wire  [ddr_ctrl_pkg::DATA_WIDTH-1:0]  cmd_wdata,
    input  wire  [ddr_ctrl_pkg::STRB_WIDTH-1:0]  cmd_wstrb,

    output logic                                 rsp_valid,
    input  wire                                  rsp_ready,
    output logic [ddr_ctrl_pkg::ID_WIDTH-1:0]    rsp_id,
    output logic [ddr_ctrl_pkg::DATA_WIDTH-1:0]  rsp_data
);

    ddr_ctrl_pkg::cmd_t    cmd_in;
    ddr_ctrl_pkg::cmd_t    q_head;
    logic                  q_full;
    logic                  q_empty;
    logic                  q_pop;
    logic                  tag_push;
    ddr_ctrl_pkg::rd_tag_t tag;
    logic                  tag_ready;

    app_if app ();

    assign cmd_in = '{
        is_read: cmd_read,
        id:      cmd_id,
        addr:    cmd_addr,
        wdata:   cmd_wdata,
        wstrb:   cmd_wstrb
    };

    assign cmd_ready = ~q_full;

    sync_fifo #(
        .item_t (ddr_ctrl_pkg::cmd_t),
        .DEPTH  (CMD_DEPTH)
    ) u_cmd_q (
        .ui_clk (ui_clk),
        .resetn (resetn),
        .push   (cmd_valid),
        .din    (cmd_in),
        .full   (q_full),
        .pop    (q_pop),
        .dout   (q_head),
        .empty  (q_empty)
    );

    cmd_fetch u_fetch (
        .ui_clk    (ui_clk),
        .resetn    (resetn),
        .q_head    (q_head),
        .q_empty   (q_empty),
        .q_pop     (q_pop),
        .app       (app.issuer),
        .tag_push  (tag_push),
        .tag       (tag),
        .tag_ready (tag_ready)
    );

    app_ram #(
        .RD_LATENCY       (RD_LATENCY),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .REFRESH_CYCLES   (REFRESH_CYCLES)
    ) u_ram (
        .ui_clk (ui_clk),
        .resetn (resetn),
        .app    (app.mem)
    );

    rd_resp_merge #(
        .TAG_DEPTH (TAG_DEPTH)
    ) u_merge (
        .ui_clk    (ui_clk),
        .resetn    (resetn),
        .tag_push  (tag_push),
        .tag       (tag),
        .tag_ready (tag_ready),
        .app       (app.rd_sink),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_id    (rsp_id),
        .rsp_data  (rsp_data)
    );

endmodule

`default_nettype wire

// ==== verification/ddr_ctrl_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module ddr_ctrl_props (
    input wire                                 ui_clk,
    input wire                                 resetn,
    input wire                                 cmd_valid,
    input wire                                 cmd_ready,
    input wire                                 q_pop,
    input wire                                 rsp_valid,
    input wire                                 rsp_ready,
    input wire [ddr_ctrl_pkg::ID_WIDTH-1:0]    rsp_id,
    input wire [ddr_ctrl_pkg::DATA_WIDTH-1:0]  rsp_data
);

    int fail_cnt = 0;

    rsp_idle_after_reset: assert property (@(posedge ui_clk) !resetn |=> !rsp_valid)
        else begin
            $error("rsp_valid high in the cycle after reset");
            fail_cnt++;
        end

    // held response must not move
    rsp_held_stable: assert property (@(posedge ui_clk) disable iff (!resetn)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_id) && $stable(rsp_data))
        else begin
            $error("response changed while rsp_ready was low");
            fail_cnt++;
        end

    cmd_ready_no_rise: assert property (@(posedge ui_clk) disable iff (!resetn)
        cmd_valid && !q_pop |=> !$rose(cmd_ready))    // room only comes from a pop
        else begin
            $error("cmd_ready rose with commands pushed and none popped");
            fail_cnt++;
        end

endmodule

bind ddr_ctrl_top ddr_ctrl_props u_props (
    .ui_clk    (ui_clk),
    .resetn    (resetn),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .q_pop     (q_pop),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_id    (rsp_id),
    .rsp_data  (rsp_data)
);

`default_nettype wire

// ==== verification/tb_ddr_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ddr_ctrl;

    localparam int AW = ddr_ctrl_pkg::ADDR_WIDTH;
    localparam int DW = ddr_ctrl_pkg::DATA_WIDTH;
    localparam int SW = ddr_ctrl_pkg::STRB_WIDTH;
    localparam int ID_W = ddr_ctrl_pkg::ID_WIDTH;
    localparam int RD_LATENCY = 3;
    localparam int REFRESH_INTERVAL = 64;
    localparam int REFRESH_CYCLES = 4;
    localparam int N_BURST = 12;
    localparam int N_BP = 20;
    localparam int N_MIX = 200;
    localparam int STALL = REFRESH_CYCLES + RD_LATENCY + 8;    // longer than any refresh stall
    localparam int CMD_CYCLES = RD_LATENCY + 6;
    localparam int TEST_CYCLES = (2 + 5 + 2 * N_BURST + N_BP + 16 + N_MIX) * CMD_CYCLES + STALL;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES
                               + (TEST_CYCLES / REFRESH_INTERVAL + 1) * REFRESH_CYCLES;

    logic                ui_clk = 1'b0;
    logic                resetn;
    logic                cmd_valid;
    logic                cmd_ready;
    logic                cmd_read;
    logic [ID_W-1:0]     cmd_id;
    logic [AW-1:0]       cmd_addr;
    logic [DW-1:0]       cmd_wdata;
    logic [SW-1:0]       cmd_wstrb;
    logic                rsp_valid;
    logic                rsp_ready;
    logic [ID_W-1:0]     rsp_id;
    logic [DW-1:0]       rsp_data;

    ddr_ctrl_pkg::data_t ref_mem [2**AW];
    logic [ID_W-1:0]     exp_id [$];
    ddr_ctrl_pkg::data_t exp_data [$];
    logic [15:0]         lfsr = 16'd15;
    string               test_name = "reset";
    int                  errors = 0;
    int                  err_mark = 0;
    int                  checks = 0;
    int                  tests_run = 0;
    int                  cycle_cnt = 0;

    always #50 ui_clk = ~ui_clk;

    ddr_ctrl_top #(
        .CMD_DEPTH        (4),
        .TAG_DEPTH        (8),
        .RD_LATENCY       (RD_LATENCY),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .REFRESH_CYCLES   (REFRESH_CYCLES)
    ) u_dut (
        .ui_clk    (ui_clk),
        .resetn    (resetn),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_read  (cmd_read),
        .cmd_id    (cmd_id),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_wstrb (cmd_wstrb),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_id    (rsp_id),
        .rsp_data  (rsp_data)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // scoreboard errors plus bound assertion failures
    function automatic int total_errors();
        return errors + u_dut.u_props.fail_cnt;
    endfunction

    // holds valid until cmd_ready and predicts the result
    task automatic send(input logic rd, input logic [ID_W-1:0] id, input logic [AW-1:0] addr,
                        input logic [DW-1:0] wdata, input logic [SW-1:0] wstrb);
        @(negedge ui_clk);
        cmd_valid = 1'b1;
        cmd_read  = rd;
        cmd_id    = id;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_wstrb = wstrb;
        while (!cmd_ready) begin
            @(negedge ui_clk);
        end
        if (rd) begin
            exp_id.push_back(id);
            exp_data.push_back(ref_mem[addr]);
        end else begin
            for (int b = 0; b < SW; b++) begin
                if (wstrb[b]) begin
                    ref_mem[addr][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic release_cmd();
        @(negedge ui_clk);
        cmd_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = total_errors();
    endtask

    task automatic finish_test();
        while (exp_id.size() != 0) begin
            @(negedge ui_clk);
        end
        repeat (4) @(negedge ui_clk);
        tests_run++;
        $display("test %s finished, errors=%0d", test_name, total_errors() - err_mark);
    endtask

    // scoreboard on every response transfer
    always @(posedge ui_clk) begin
        if (resetn && rsp_valid && rsp_ready) begin
            if (exp_id.size() == 0) begin
                $display("Error in test %s: response id %0d arrived with no read outstanding",
                         test_name, rsp_id);
                errors++;
            end else begin
                checks++;
                assert (rsp_id == exp_id[0] && rsp_data == exp_data[0]) else begin
                    $display("Error in test %s: expected id %0d data %h, actual id %0d data %h",
                             test_name, exp_id[0], exp_data[0], rsp_id, rsp_data);
                    errors++;
                end
                void'(exp_id.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge ui_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout in test %s after %0d cycles, %0d responses never arrived",
                     test_name, cycle_cnt, exp_id.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic stalled;
        logic sender_done;
        logic rd_sel;
        int   low_run;
        int   k;
        stalled     = 1'b0;
        sender_done = 1'b0;
        low_run     = 0;
        k           = 0;
        resetn      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_read    = 1'b0;
        cmd_id      = '0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        cmd_wstrb   = '0;
        rsp_ready   = 1'b1;
        repeat (2) @(negedge ui_clk);
        resetn = 1'b1;

        start_test("full_write_read");
        send(1'b0, ID_W'(1), AW'(8'h10), rand_bits(DW), '1);
        send(1'b1, ID_W'(2), AW'(8'h10), '0, '0);
        release_cmd();
        finish_test();

        start_test("partial_write");
        send(1'b0, ID_W'(3), AW'(8'h20), rand_bits(DW), '1);
        send(1'b0, ID_W'(4), AW'(8'h20), rand_bits(DW), SW'(4'b0101));
        send(1'b1, ID_W'(5), AW'(8'h20), '0, '0);
        send(1'b0, ID_W'(6), AW'(8'h20), rand_bits(DW), SW'(4'b1000));
        send(1'b1, ID_W'(7), AW'(8'h20), '0, '0);
        release_cmd();
        finish_test();

        start_test("reads_in_flight");
        for (int i = 0; i < N_BURST; i++) begin
            send(1'b0, ID_W'(i), AW'(8'h40 + i), rand_bits(DW), '1);
        end
        for (int i = 0; i < N_BURST; i++) begin
            send(1'b1, ID_W'(i + 3), AW'(8'h40 + i), '0, '0);    // back to back
        end
        release_cmd();
        finish_test();

        start_test("response_backpressure");
        @(negedge ui_clk);
        rsp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < N_BP; i++) begin
                    send(1'b1, ID_W'(i), AW'(8'h40 + (i % N_BURST)), '0, '0);
                end
                sender_done = 1'b1;
            end
            begin
                while (!stalled && !sender_done) begin
                    @(negedge ui_clk);
                    low_run = cmd_ready ? 0 : low_run + 1;
                    if (low_run >= STALL) begin
                        stalled = 1'b1;
                    end
                end
                rsp_ready = 1'b1;
            end
        join
        release_cmd();
        assert (stalled) else begin
            $display("Error in test %s: cmd_ready never dropped while responses were held back",
                     test_name);
            errors++;
        end
        finish_test();

        start_test("refresh_mixed");
        sender_done = 1'b0;
        for (int i = 0; i < 16; i++) begin
            send(1'b0, ID_W'(i), AW'(8'h80 + i), rand_bits(DW), '1);
        end
        fork
            begin
                for (int i = 0; i < N_MIX; i++) begin
                    rd_sel = (rand_bits(1) != 32'd0);
                    send(rd_sel, ID_W'(rand_bits(ID_W)), AW'(8'h80 + rand_bits(4)),
                         rand_bits(DW), SW'(rand_bits(SW)));
                end
                sender_done = 1'b1;
            end
            begin
                while (!sender_done) begin
                    @(negedge ui_clk);
                    rsp_ready = (k % 5) != 3;    // short gaps on the response side
                    k++;
                end
            end
        join
        release_cmd();
        rsp_ready = 1'b1;
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/ddr_ctrl_pkg.sv
hw/app_if.sv
hw/sync_fifo.sv
hw/cmd_fetch.sv
hw/rd_resp_merge.sv
hw/app_ram.sv
hw/ddr_ctrl_top.sv
verification/ddr_ctrl_props.sv
verification/tb_ddr_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the DDR application-side controller

VERILATOR ?= verilator
TOP       ?= tb_ddr_ctrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= No errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed, see $(LOG)"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
